//--- flist.f
verilog/wbi_pkg.sv
verilog/wbi_rr_arbiter.sv
verilog/wbi_slave_port.sv
verilog/wbi_master_port.sv
verilog/wb_interconnect.sv
dv/wbi_slave_bfm.sv
dv/tb_wb_interconnect.sv

//--- Makefile
VERILATOR   ?= verilator
TOP         ?= tb_wb_interconnect
FLIST       ?= flist.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
VFLAGS      ?= --timing --assert
BUILD_FLAGS ?= -Wno-fatal

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(SIM_BIN): $(shell cat $(FLIST))
	$(VERILATOR) --binary $(VFLAGS) $(BUILD_FLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/tb_wb_interconnect.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wb_interconnect;

  localparam int NXFER   = 60;
  localparam int ACK_TMO = 64;

  logic              clk;
  logic              rst_n;
  wbi_pkg::wbi_req_t m_req [wbi_pkg::NUM_MASTERS];
  wbi_pkg::wbi_rsp_t m_rsp [wbi_pkg::NUM_MASTERS];
  wbi_pkg::wbi_req_t s_req [wbi_pkg::NUM_SLAVES];
  wbi_pkg::wbi_rsp_t s_rsp [wbi_pkg::NUM_SLAVES];
  logic [31:0]       last_adr [wbi_pkg::NUM_SLAVES];

  // Reference memories, keyed by target id and word address
  logic [31:0] model_mem [logic [31:0]];
  int          mis_cnt;
  int          tmo_cnt;
  int          proto_cnt;
  int          ack_cnt [wbi_pkg::NUM_MASTERS];
  int          done_cnt [wbi_pkg::NUM_MASTERS];
  // Last served master per target, no owner yet means master 0 is next
  int          last_own [wbi_pkg::NUM_SLAVES] = '{2, 2, 2};
  int          seq_tgt = -1;
  int          seq_q [$];

  wb_interconnect dut_i (
    .clk_i   (clk),
    .rst_n_i (rst_n),
    .m_req_i (m_req),
    .m_rsp_o (m_rsp),
    .s_req_o (s_req),
    .s_rsp_i (s_rsp)
  );

  for (genvar s = 0; s < wbi_pkg::NUM_SLAVES; s++) begin : gen_bfm
    wbi_slave_bfm u_bfm (.clk_i (clk), .rst_n_i (rst_n), .req_i (s_req[s]),
                         .rsp_o (s_rsp[s]), .last_adr_o (last_adr[s]));
  end

  always #10 clk = ~clk;

  // --------------------------------------------------------------------------
  // Reference model and compares
  // --------------------------------------------------------------------------
  function automatic logic [31:0] blank_word(input logic [31:0] adr);
    return {adr[31:2], 2'b00} ^ 32'h5AC3_3CA5;
  endfunction

  // Region 0 and page 0x1000 are memory, holes too
  function automatic wbi_pkg::wbi_tid_t decode_target(input logic [31:0] adr);
    if (adr[31:28] == 4'h0) return wbi_pkg::TGT_MEM;
    if (adr[31:16] == 16'h1001) return wbi_pkg::TGT_UART;
    if (adr[31:16] == 16'h1002) return wbi_pkg::TGT_PINMUX;
    return wbi_pkg::TGT_MEM;
  endfunction

  task automatic report_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] got);
    $display("ERR %s exp=%h got=%h", what, exp, got);
    mis_cnt++;
  endtask

  task automatic rsp_compare(input string what, input wbi_pkg::wbi_rsp_t exp,
                             input wbi_pkg::wbi_rsp_t got);
    if (got !== exp) report_mismatch(what, 64'(exp), 64'(got));
  endtask

  task automatic tid_compare(input string what, input wbi_pkg::wbi_tid_t exp,
                             input wbi_pkg::wbi_tid_t got);
    if (got !== exp) report_mismatch(what, 64'(exp), 64'(got));
  endtask

  task automatic owner_compare(input string what, input wbi_pkg::wbi_mvec_t exp,
                               input wbi_pkg::wbi_mvec_t got);
    if (got !== exp) report_mismatch(what, 64'(exp), 64'(got));
  endtask

  // --------------------------------------------------------------------------
  // Master side
  // --------------------------------------------------------------------------
  task automatic transfer(input int m, input logic [31:0] adr, input logic we,
                          input logic [3:0] sel, input logic [31:0] dat);
    wbi_pkg::wbi_req_t req;
    wbi_pkg::wbi_rsp_t exp;
    wbi_pkg::wbi_tid_t tid;
    wbi_pkg::wbi_tid_t hit;
    logic [31:0]       key;
    logic              got;
    tid     = decode_target(adr);
    key     = {tid, adr[31:2]};
    exp.ack = 1'b1;
    exp.dat = model_mem.exists(key) ? model_mem[key] : blank_word(adr);
    req     = '{dat: dat, adr: adr, sel: sel, we: we, cyc: 1'b1, stb: 1'b1};
    @(posedge clk);
    #2 m_req[m] = req;
    got = 1'b0;
    for (int n = 0; n < ACK_TMO && !got; n++) begin
      @(negedge clk);
      got = m_rsp[m].ack;
    end
    if (!got) begin
      $display("master %0d got no ack within %0d cycles at address %h", m, ACK_TMO, adr);
      tmo_cnt++;
    end else begin
      // Only the target serving this exact address acks now
      hit = 2'd3;
      for (int s = 0; s < wbi_pkg::NUM_SLAVES; s++)
        if (s_rsp[s].ack && last_adr[s] == adr) hit = wbi_pkg::wbi_tid_t'(s);
      tid_compare($sformatf("target of m_req[%0d].adr %h", m, adr), tid, hit);
      if (!we) begin
        rsp_compare($sformatf("m_rsp[%0d] adr %h", m, adr), exp, m_rsp[m]);
      end else begin
        for (int b = 0; b < wbi_pkg::SW; b++)
          if (sel[b]) exp.dat[8*b +: 8] = dat[8*b +: 8];
        model_mem[key] = exp.dat;
      end
    end
    done_cnt[m]++;
    // At least one idle cycle between transfers
    @(posedge clk);
    #2 m_req[m] = '0;
  endtask

  task automatic random_master(input int m);
    logic [15:0] page;
    for (int i = 0; i < NXFER; i++) begin
      case ($urandom % 5)
        0: page = 16'($urandom % 4);
        1: page = wbi_pkg::PAGE_MEM_REG;
        2: page = wbi_pkg::PAGE_UART;
        3: page = wbi_pkg::PAGE_PINMUX;
        // Outside every mapped window
        default: page = ($urandom % 2) ? 16'h1003 : 16'h7F00 + 16'($urandom % 8);
      endcase
      repeat ($urandom % 3) @(posedge clk);
      // Bits 9:8 name the master, offsets never collide
      transfer(m, {page, 6'd0, 2'(m), 2'b00, 4'($urandom), 2'b00},
               1'($urandom), 4'($urandom), $urandom);
    end
  endtask

  // Ack bookkeeping and served order per target
  always @(negedge clk) begin
    if (rst_n) begin
      for (int i = 0; i < wbi_pkg::NUM_MASTERS; i++) begin
        if (m_rsp[i].ack) begin
          ack_cnt[i]++;
          if (!m_req[i].cyc) begin
            $display("master %0d saw an ack while idle", i);
            proto_cnt++;
          end
        end
        if (s_rsp[i].ack) begin
          last_own[i] = int'(s_req[i].adr[9:8]);
          if (i == seq_tgt) seq_q.push_back(last_own[i]);
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Sequence
  // --------------------------------------------------------------------------
  initial begin
    int first;
    void'($urandom(18152));
    clk   = 1'b0;
    rst_n = 1'b0;
    for (int m = 0; m < wbi_pkg::NUM_MASTERS; m++) m_req[m] = '0;
    repeat (8) @(posedge clk);
    #2 rst_n = 1'b1;
    // Quiet bus while every master is idle
    for (int n = 0; n < 20; n++) begin
      @(negedge clk);
      for (int i = 0; i < 3; i++)
        if (s_req[i].stb || m_rsp[i].ack) begin
          $display("port %0d active while all masters are idle", i);
          proto_cnt++;
        end
    end
    fork
      random_master(0);
      random_master(1);
      random_master(2);
    join
    // All three masters on one target in the same cycle, pages 0x1000 to 0x1002
    for (int t = 0; t < wbi_pkg::NUM_SLAVES; t++) begin
      first   = (last_own[t] + 1) % 3;
      seq_tgt = t;
      seq_q.delete();
      fork
        transfer(0, {wbi_pkg::PAGE_MEM_REG + 16'(t), 16'h00F0}, 1'b1, 4'hF, $urandom);
        transfer(1, {wbi_pkg::PAGE_MEM_REG + 16'(t), 16'h01F0}, 1'b1, 4'hF, $urandom);
        transfer(2, {wbi_pkg::PAGE_MEM_REG + 16'(t), 16'h02F0}, 1'b1, 4'hF, $urandom);
      join
      seq_tgt = -1;
      if (seq_q.size() != 3) begin
        $display("target %0d served %0d of 3 contending masters", t, seq_q.size());
        proto_cnt++;
      end else begin
        for (int i = 0; i < 3; i++)
          owner_compare($sformatf("owner %0d of target %0d", i, t),
                        wbi_pkg::wbi_mvec_t'(1 << ((first + i) % 3)),
                        wbi_pkg::wbi_mvec_t'(1 << seq_q[i]));
      end
    end
    repeat (4) @(posedge clk);
    for (int m = 0; m < wbi_pkg::NUM_MASTERS; m++)
      if (ack_cnt[m] != done_cnt[m]) begin
        $display("master %0d saw %0d acks for %0d transfers", m, ack_cnt[m], done_cnt[m]);
        proto_cnt++;
      end
    $display("errors: %0d mismatch, %0d timeout, %0d protocol", mis_cnt, tmo_cnt, proto_cnt);
    if (mis_cnt + tmo_cnt + proto_cnt == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/wbi_slave_bfm.sv
`timescale 1ns/1ps
`default_nettype none

module wbi_slave_bfm (
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,
  input  wire wbi_pkg::wbi_req_t req_i,
  output wbi_pkg::wbi_rsp_t      rsp_o,
  // Address of the most recent acked transfer
  output logic [31:0]            last_adr_o
);

  // Sparse word store, unwritten words read back a pattern of their address
  logic [31:0] mem [logic [29:0]];
  logic        busy_q;
  int          wait_q;

  function automatic logic [31:0] fill_word(input logic [31:0] adr);
    return {adr[31:2], 2'b00} ^ 32'h5AC3_3CA5;
  endfunction

  always @(posedge clk_i) begin
    int          left;
    logic [31:0] word;
    if (!rst_n_i) begin
      rsp_o      <= '0;
      busy_q     <= 1'b0;
      wait_q     <= 0;
      last_adr_o <= '0;
    end else if (rsp_o.ack) begin
      // Ack lasts a single cycle
      rsp_o.ack <= 1'b0;
    end else if (req_i.cyc && req_i.stb) begin
      // Wait states drawn once per transfer, 0 to 3
      left = busy_q ? wait_q : int'($urandom % 4);
      if (left == 0) begin
        word = mem.exists(req_i.adr[31:2]) ? mem[req_i.adr[31:2]] : fill_word(req_i.adr);
        // Read data is the word before this write
        rsp_o      <= '{dat: word, ack: 1'b1};
        busy_q     <= 1'b0;
        last_adr_o <= req_i.adr;
        if (req_i.we) begin
          for (int b = 0; b < wbi_pkg::SW; b++)
            if (req_i.sel[b]) word[8*b +: 8] = req_i.dat[8*b +: 8];
          mem[req_i.adr[31:2]] = word;
        end
      end else begin
        busy_q <= 1'b1;
        wait_q <= left - 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/wb_interconnect.sv
`timescale 1ns/1ps
`default_nettype none

module wb_interconnect (
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,
  // Host, instruction fetch and data port in that order
  input  wire wbi_pkg::wbi_req_t m_req_i [wbi_pkg::NUM_MASTERS],
  output wbi_pkg::wbi_rsp_t      m_rsp_o [wbi_pkg::NUM_MASTERS],
  // Memory, UART cluster and pin-mux in that order
  output wbi_pkg::wbi_req_t      s_req_o [wbi_pkg::NUM_SLAVES],
  input  wire wbi_pkg::wbi_rsp_t s_rsp_i [wbi_pkg::NUM_SLAVES]
);

  // --------------------------------------------------------------------------
  // Crossing wires
  // --------------------------------------------------------------------------
  // Request bits, indexed by master then by target
  wbi_pkg::wbi_mvec_t      mst_bits [wbi_pkg::NUM_MASTERS];
  // Same bits regrouped by target then by master
  wire wbi_pkg::wbi_mvec_t slv_bits [wbi_pkg::NUM_SLAVES];

  // Gated responses as produced, by target then master
  wbi_pkg::wbi_rsp_t       slv_rsp [wbi_pkg::NUM_SLAVES][wbi_pkg::NUM_MASTERS];
  // And as consumed, by master then target
  wire wbi_pkg::wbi_rsp_t  mst_rsp [wbi_pkg::NUM_MASTERS][wbi_pkg::NUM_SLAVES];

  // Transpose between the master and target views
  for (genvar s = 0; s < wbi_pkg::NUM_SLAVES; s++) begin : gen_xs
    for (genvar m = 0; m < wbi_pkg::NUM_MASTERS; m++) begin : gen_xm
      assign slv_bits[s][m] = mst_bits[m][s];
      assign mst_rsp[m][s]  = slv_rsp[s][m];
    end
  end

  // --------------------------------------------------------------------------
  // Master side
  // --------------------------------------------------------------------------
  for (genvar m = 0; m < wbi_pkg::NUM_MASTERS; m++) begin : gen_mst
    wbi_master_port u_mst (
      .req_i     (m_req_i[m]),
      .slv_req_o (mst_bits[m]),
      .slv_rsp_i (mst_rsp[m]),
      .rsp_o     (m_rsp_o[m])
    );
  end

  // --------------------------------------------------------------------------
  // Target side
  // --------------------------------------------------------------------------
  for (genvar s = 0; s < wbi_pkg::NUM_SLAVES; s++) begin : gen_slv
    // Each target runs its own arbitration
    wbi_slave_port u_slv (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .mst_req_i  (m_req_i),
      .req_bits_i (slv_bits[s]),
      .req_o      (s_req_o[s]),
      .rsp_i      (s_rsp_i[s]),
      .mst_rsp_o  (slv_rsp[s])
    );
  end

endmodule

`default_nettype wire

//--- verilog/wbi_master_port.sv
`timescale 1ns/1ps
`default_nettype none

module wbi_master_port (
  input  wire wbi_pkg::wbi_req_t  req_i,
  // One bit per target, at most one raised
  output wbi_pkg::wbi_mvec_t      slv_req_o,
  // Per target responses, already gated for this master
  input  wire wbi_pkg::wbi_rsp_t  slv_rsp_i [wbi_pkg::NUM_SLAVES],
  output wbi_pkg::wbi_rsp_t       rsp_o
);

  wbi_pkg::wbi_adr_u adr;
  wbi_pkg::wbi_tid_t tid;

  assign adr = req_i.adr;

  // --------------------------------------------------------------------------
  // Address decode
  // --------------------------------------------------------------------------
  always_comb begin
    if (adr.rgn.region == wbi_pkg::REGION_MEM) begin
      // Flash window
      tid = wbi_pkg::TGT_MEM;
    end else if (adr.pg.page == wbi_pkg::PAGE_MEM_REG) begin
      // Memory controller registers sit on the memory port
      tid = wbi_pkg::TGT_MEM;
    end else if (adr.pg.page == wbi_pkg::PAGE_UART) begin
      tid = wbi_pkg::TGT_UART;
    end else if (adr.pg.page == wbi_pkg::PAGE_PINMUX) begin
      tid = wbi_pkg::TGT_PINMUX;
    end else begin
      // Holes in the map fall back to memory
      tid = wbi_pkg::TGT_MEM;
    end
  end

  // Raise the bit of the decoded target while a transfer is live
  always_comb begin
    slv_req_o      = '0;
    slv_req_o[tid] = req_i.cyc & req_i.stb;
    assert ($onehot0(slv_req_o) && ((|slv_req_o) == (req_i.cyc & req_i.stb)))
      else $error("wbi_master_port: request vector not one-hot or zero");
  end

  // Same id picks the response, so a stray ack elsewhere is ignored
  assign rsp_o = slv_rsp_i[tid];

endmodule

`default_nettype wire

//--- verilog/wbi_slave_port.sv
`timescale 1ns/1ps
`default_nettype none

module wbi_slave_port (
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,
  // Only the owner's raw request is forwarded
  input  wire wbi_pkg::wbi_req_t  mst_req_i [wbi_pkg::NUM_MASTERS],
  // Which masters currently address this target
  input  wire wbi_pkg::wbi_mvec_t req_bits_i,
  output wbi_pkg::wbi_req_t       req_o,
  input  wire wbi_pkg::wbi_rsp_t  rsp_i,
  output wbi_pkg::wbi_rsp_t       mst_rsp_o [wbi_pkg::NUM_MASTERS]
);

  wbi_pkg::wbi_mvec_t gnt;

  // --------------------------------------------------------------------------
  // Ownership
  // --------------------------------------------------------------------------
  wbi_rr_arbiter u_arb (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (req_bits_i),
    .gnt_o   (gnt)
  );

  // --------------------------------------------------------------------------
  // Request path toward the target
  // --------------------------------------------------------------------------
  always_comb begin
    // Idle bus when nobody owns the port
    req_o = '0;
    for (int m = 0; m < wbi_pkg::NUM_MASTERS; m++) begin
      if (gnt[m]) begin
        // Owner's request passes through untouched
        req_o = mst_req_i[m];
      end
    end
  end

  // --------------------------------------------------------------------------
  // Response path back to the masters
  // --------------------------------------------------------------------------
  always_comb begin
    for (int m = 0; m < wbi_pkg::NUM_MASTERS; m++) begin
      // Read data fans out unqualified
      mst_rsp_o[m].dat = rsp_i.dat;
      // Only the owner may see the ack
      mst_rsp_o[m].ack = rsp_i.ack & gnt[m];
    end
  end

  // Target never sees a strobe outside a cycle
  stb_in_cyc_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_o.stb |-> req_o.cyc);

  // Ack relies on the target only answering an active strobe
  for (genvar m = 0; m < wbi_pkg::NUM_MASTERS; m++) begin : gen_ack_chk
    ack_in_cyc_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mst_rsp_o[m].ack |-> mst_req_i[m].cyc);
  end

endmodule

`default_nettype wire

//--- verilog/wbi_rr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wbi_rr_arbiter (
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,
  input  wire wbi_pkg::wbi_mvec_t req_i,
  output wbi_pkg::wbi_mvec_t      gnt_o
);

  wbi_pkg::wbi_mvec_t gnt_q;
  wbi_pkg::wbi_mvec_t gnt_d;
  // Index of the master that owned the port most recently
  logic [$clog2(wbi_pkg::NUM_MASTERS)-1:0] last_q;
  logic [$clog2(wbi_pkg::NUM_MASTERS)-1:0] last_d;
  logic                                    owner_busy;

  // Owner still holding its request keeps the port
  assign owner_busy = |(gnt_q & req_i);

  // --------------------------------------------------------------------------
  // Next owner search
  // --------------------------------------------------------------------------
  always_comb begin
    int   idx;
    logic found;
    gnt_d  = gnt_q;
    last_d = last_q;
    found  = 1'b0;
    idx    = 0;
    if (!owner_busy) begin
      // Port free or owner released, rescan
      gnt_d = '0;
      // Start one past the last owner, wrap around
      for (int off = 1; off <= wbi_pkg::NUM_MASTERS; off++) begin
        idx = (int'(last_q) + off) % wbi_pkg::NUM_MASTERS;
        if (!found && req_i[idx]) begin
          found      = 1'b1;
          gnt_d[idx] = 1'b1;
          last_d     = idx[$bits(last_d)-1:0];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      gnt_q  <= '0;
      // Pointer parked on the last master so master 0 goes first
      last_q <= $bits(last_q)'(wbi_pkg::NUM_MASTERS - 1);
    end else begin
      gnt_q  <= gnt_d;
      last_q <= last_d;
    end
  end

  assign gnt_o = gnt_q;

  // At most one owner per target
  gnt_onehot_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(gnt_o));

  // Grant only ever lands on a master that was requesting one edge earlier
  gnt_req_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    |gnt_o |-> ((gnt_o & $past(req_i)) == gnt_o));

endmodule

`default_nettype wire

//--- verilog/wbi_pkg.sv
`default_nettype none

package wbi_pkg;

  // --------------------------------------------------------------------------
  // Bus geometry
  // --------------------------------------------------------------------------
  localparam int NUM_MASTERS = 3;
  localparam int NUM_SLAVES  = 3;
  localparam int DW          = 32;
  localparam int AW          = 32;
  localparam int SW          = 4;
  localparam int TID_W       = 2;

  // Target id, one per slave port
  typedef logic [TID_W-1:0] wbi_tid_t;

  // One bit per master, used for request and grant vectors
  typedef logic [NUM_MASTERS-1:0] wbi_mvec_t;

  localparam wbi_tid_t TGT_MEM    = 2'd0;
  localparam wbi_tid_t TGT_UART   = 2'd1;
  localparam wbi_tid_t TGT_PINMUX = 2'd2;

  // --------------------------------------------------------------------------
  // Memory map
  // --------------------------------------------------------------------------
  // Whole low 256MB region is external memory
  localparam logic [3:0]  REGION_MEM   = 4'h0;
  // 64KB pages in the 0x1xxx_xxxx space
  localparam logic [15:0] PAGE_MEM_REG = 16'h1000;
  localparam logic [15:0] PAGE_UART    = 16'h1001;
  localparam logic [15:0] PAGE_PINMUX  = 16'h1002;

  // Master side request, also what a target sees
  typedef struct packed {
    logic [DW-1:0] dat;
    logic [AW-1:0] adr;
    logic [SW-1:0] sel;
    logic          we;
    logic          cyc;
    logic          stb;
  } wbi_req_t;

  // Read data and ack back toward a master
  typedef struct packed {
    logic [DW-1:0] dat;
    logic          ack;
  } wbi_rsp_t;

  // Address seen as region nibble plus offset
  typedef struct packed {
    logic [3:0]    region;
    logic [AW-5:0] offset;
  } wbi_adr_rgn_t;

  // Address seen as 64KB page plus offset
  typedef struct packed {
    logic [AW/2-1:0] page;
    logic [AW/2-1:0] offset;
  } wbi_adr_pg_t;

  // Both views of one address word, the decoder uses each
  typedef union packed {
    wbi_adr_rgn_t rgn;
    wbi_adr_pg_t  pg;
  } wbi_adr_u;

endpackage

`default_nettype wire
